// File: source/biu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bus interface unit shared definitions
// cycle kinds, bus engine state codes, request and response structs
////////////////////////////////////////////////////////////////////////////
package biu_pkg;

    typedef enum logic [2:0] {
        cyc_mem_rd = 3'd0,
        cyc_mem_wr = 3'd1,
        cyc_io_rd  = 3'd2,
        cyc_io_wr  = 3'd3,
        cyc_inta   = 3'd4
    } cycle_kind_e;

    typedef enum logic [2:0] {
        st_idle = 3'd0,
        st_t1   = 3'd1,
        st_t2   = 3'd2,
        st_t3   = 3'd3,
        st_tw   = 3'd4,
        st_t4   = 3'd5
    } bus_state_e;

    typedef struct packed {
        logic [19:0] addr;     // physical address
        logic [15:0] wdata;    // low byte goes out first
        cycle_kind_e kind;
        logic        word;     // two byte cycles
    } bus_req_t;

    typedef struct packed {
        logic [15:0] rdata;    // low byte came first
        logic        done;     // one cycle pulse
    } bus_rsp_t;

    function automatic logic kind_is_write(cycle_kind_e kind);
        return kind inside {cyc_mem_wr, cyc_io_wr};
    endfunction

    function automatic logic kind_is_io(cycle_kind_e kind);
        return kind inside {cyc_io_rd, cyc_io_wr, cyc_inta};
    endfunction

endpackage

// File: source/bus_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// fixed priority bus arbiter
// interrupt ack over exec port over prefetch, plus hold handover
////////////////////////////////////////////////////////////////////////////
module bus_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              pf_req_i,
    input  logic              exec_req_i,
    input  logic              ia_req_i,
    input  biu_pkg::bus_req_t pf_data_i,
    input  biu_pkg::bus_req_t exec_data_i,
    input  biu_pkg::bus_req_t ia_data_i,
    output biu_pkg::bus_rsp_t pf_rsp_o,
    output biu_pkg::bus_rsp_t exec_rsp_o,
    output biu_pkg::bus_rsp_t ia_rsp_o,
    input  logic              hold_i,
    output logic              hlda_o,
    output logic              start_o,
    output biu_pkg::bus_req_t cyc_req_o,
    input  biu_pkg::bus_rsp_t cyc_rsp_i
);

    typedef enum logic [1:0] {
        arb_free,
        arb_granted,
        arb_held
    } arb_state_e;

    arb_state_e state_q;
    logic [2:0] grant_q;    // {ia, exec, pf}
    logic [2:0] winner;
    logic       start_q;

    always_comb begin
        winner = 3'b000;
        if (ia_req_i)
            winner = 3'b100;
        else if (exec_req_i)
            winner = 3'b010;
        else if (pf_req_i)
            winner = 3'b001;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= arb_free;
            grant_q <= 3'b000;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                arb_free: begin
                    if (hold_i) begin
                        state_q <= arb_held;                // hold wins between cycles
                    end else if (winner != 3'b000) begin
                        state_q <= arb_granted;
                        grant_q <= winner;
                        start_q <= 1'b1;
                    end
                end
                arb_granted: begin
                    if (cyc_rsp_i.done) begin
                        state_q <= arb_free;
                        grant_q <= 3'b000;
                    end
                end
                arb_held: begin
                    if (!hold_i)
                        state_q <= arb_free;
                end
                default: state_q <= arb_free;
            endcase
        end
    end

    assign hlda_o  = (state_q == arb_held);
    assign start_o = start_q;

    always_comb begin
        cyc_req_o = pf_data_i;
        if (grant_q[2])
            cyc_req_o = ia_data_i;
        else if (grant_q[1])
            cyc_req_o = exec_data_i;
    end

    // rdata goes everywhere, done only to the owner
    always_comb begin
        pf_rsp_o        = cyc_rsp_i;
        exec_rsp_o      = cyc_rsp_i;
        ia_rsp_o        = cyc_rsp_i;
        pf_rsp_o.done   = cyc_rsp_i.done & grant_q[0];
        exec_rsp_o.done = cyc_rsp_i.done & grant_q[1];
        ia_rsp_o.done   = cyc_rsp_i.done & grant_q[2];
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst)
        (state_q == arb_granted) |-> $onehot(grant_q));

endmodule

// File: source/bus_cycle_fsm.sv
////////////////////////////////////////////////////////////////////////////
// minimum mode bus cycle engine
// T1-T4 byte cycles with wait states, word splitting, strobes, ad drive
////////////////////////////////////////////////////////////////////////////
module bus_cycle_fsm (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  biu_pkg::bus_req_t req_i,
    output biu_pkg::bus_rsp_t rsp_o,
    input  logic              float_i,
    input  logic              ready_i,
    output logic [19:0]       a_o,
    inout  wire  [7:0]        ad_io,
    output logic              ale_o,
    output logic              rd_n_o,
    output logic              wr_n_o,
    output logic              inta_n_o,
    output logic              den_n_o,
    output logic              dt_r_o,
    output logic              iom_o
);
    import biu_pkg::*;

    bus_state_e  state_q;
    bus_state_e  state_d;
    bus_req_t    req_q;
    logic        byte_q;        // 0 low byte, 1 high byte
    logic [15:0] rdata_q;
    logic        done_q;
    logic        last_byte;
    logic        cmd_phase;     // t2 through t4
    logic        is_write;
    logic        is_inta;
    logic        ad_oe;
    logic [7:0]  ad_out;

    assign last_byte = !req_q.word || byte_q;
    assign is_write  = kind_is_write(req_q.kind);
    assign is_inta   = (req_q.kind == cyc_inta);
    assign cmd_phase = state_q inside {st_t2, st_t3, st_tw, st_t4};

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start_i)
                    state_d = st_t1;
            end
            st_t1:   state_d = st_t2;
            st_t2:   state_d = st_t3;
            st_t3,
            st_tw:   state_d = ready_i ? st_t4 : st_tw;   // ready sampled here
            st_t4:   state_d = last_byte ? st_idle : st_t1;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= st_idle;
            byte_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == st_t4) && last_byte;
            if (state_q == st_t4)
                byte_q <= !last_byte;                     // second half of a word next
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            req_q   <= req_i;
            rdata_q <= 16'h0000;
        end else if (state_q == st_t4 && !is_write) begin
            if (byte_q)
                rdata_q[15:8] <= ad_io;
            else
                rdata_q[7:0] <= ad_io;
        end
    end

    assign rsp_o = {rdata_q, done_q};

    assign a_o      = req_q.addr + 20'(byte_q);
    assign ale_o    = (state_q == st_t1);
    assign rd_n_o   = !(cmd_phase && !is_write && !is_inta);
    assign wr_n_o   = !(cmd_phase && is_write);
    assign inta_n_o = !(cmd_phase && is_inta);
    assign den_n_o  = !cmd_phase;
    assign dt_r_o   = !cmd_phase || is_write;            // low only while receiving
    assign iom_o    = kind_is_io(req_q.kind);

    // address in T1, write byte from T2 on
    assign ad_oe  = !float_i && (ale_o || (cmd_phase && is_write));
    assign ad_out = ale_o  ? a_o[7:0] :
                    byte_q ? req_q.wdata[15:8] : req_q.wdata[7:0];
    assign ad_io  = ad_oe ? ad_out : 8'hzz;

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({~rd_n_o, ~wr_n_o, ~inta_n_o}));

    // T1 follows a start or the first byte of a word
    a_ale_t1: assert property (@(posedge clk) disable iff (!rst)
        ale_o |-> $past(start_i) || $past(state_q == st_t4 && !last_byte));

    a_start_idle: assert property (@(posedge clk) disable iff (!rst)
        start_i |-> (state_q == st_idle));

endmodule

// File: source/prefetch_queue.sv
////////////////////////////////////////////////////////////////////////////
// instruction prefetch queue
// circular byte buffer filled by word reads, flushed on a jump
////////////////////////////////////////////////////////////////////////////
module prefetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush_i,
    input  logic [19:0]       flush_addr_i,
    input  logic              pop_i,
    output logic [7:0]        byte_o,
    output logic              valid_o,
    output logic              req_o,
    output biu_pkg::bus_req_t req_data_o,
    input  biu_pkg::bus_rsp_t rsp_i
);
    import biu_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [7:0]       mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [19:0]      fetch_addr_q;   // next byte to fetch
    logic [19:0]      req_addr_q;     // word currently requested
    logic             req_q;
    logic             discard_q;      // in-flight word is stale
    logic             do_pop;
    logic             do_fill;
    logic             room;
    logic             raise;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign valid_o = (count_q != '0);
    assign byte_o  = mem_q[rd_ptr_q];
    assign do_pop  = pop_i && valid_o && !flush_i;
    assign do_fill = rsp_i.done && !discard_q && !flush_i;
    assign room    = (count_q <= CNT_W'(QUEUE_DEPTH - 2));   // two bytes free
    assign raise   = !req_q && !flush_i && room;

    assign req_o      = req_q;
    assign req_data_o = '{addr: req_addr_q, wdata: 16'h0000, kind: cyc_mem_rd, word: 1'b1};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_ptr_q     <= '0;
            wr_ptr_q     <= '0;
            count_q      <= '0;
            fetch_addr_q <= 20'h00000;
            req_q        <= 1'b0;
            discard_q    <= 1'b0;
        end else begin
            if (flush_i) begin
                rd_ptr_q     <= '0;
                wr_ptr_q     <= '0;
                count_q      <= '0;
                fetch_addr_q <= flush_addr_i;
            end else begin
                if (do_pop)
                    rd_ptr_q <= ptr_inc(rd_ptr_q);
                if (do_fill) begin
                    wr_ptr_q     <= ptr_inc(ptr_inc(wr_ptr_q));
                    fetch_addr_q <= fetch_addr_q + 20'd2;
                end
                count_q <= count_q + (do_fill ? CNT_W'(2) : CNT_W'(0))
                                   - (do_pop ? CNT_W'(1) : CNT_W'(0));
            end

            if (rsp_i.done) begin
                req_q     <= 1'b0;
                discard_q <= 1'b0;
            end else if (req_q && flush_i) begin
                discard_q <= 1'b1;                 // request stays up until done
            end else if (raise) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_fill) begin
            mem_q[wr_ptr_q]          <= rsp_i.rdata[7:0];
            mem_q[ptr_inc(wr_ptr_q)] <= rsp_i.rdata[15:8];
        end
        if (raise)
            req_addr_q <= fetch_addr_q;
    end

    a_no_overfill: assert property (@(posedge clk) disable iff (!rst)
        do_fill |-> room);

    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst)
        (pop_i && !flush_i) |-> valid_o);

endmodule

// File: source/intr_ack_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// interrupt acknowledge sequencer
// two back to back inta cycles, vector taken from the second
////////////////////////////////////////////////////////////////////////////
module intr_ack_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              intr_i,
    input  logic              if_i,
    output logic              req_o,
    output biu_pkg::bus_req_t req_data_o,
    input  biu_pkg::bus_rsp_t rsp_i,
    output logic [7:0]        vector_o,
    output logic              vector_valid_o
);
    import biu_pkg::*;

    typedef enum logic [1:0] {
        ia_idle,
        ia_first,
        ia_second,
        ia_rearm
    } ia_state_e;

    ia_state_e  state_q;
    logic [7:0] vector_q;
    logic       valid_q;

    assign req_o          = (state_q == ia_first) || (state_q == ia_second);
    assign req_data_o     = '{addr: 20'h00000, wdata: 16'h0000, kind: cyc_inta, word: 1'b0};
    assign vector_o       = vector_q;
    assign vector_valid_o = valid_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ia_idle;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                ia_idle: begin
                    if (intr_i && if_i)
                        state_q <= ia_first;
                end
                ia_first: begin
                    if (rsp_i.done)
                        state_q <= ia_second;           // req stays high
                end
                ia_second: begin
                    if (rsp_i.done) begin
                        state_q <= ia_rearm;
                        valid_q <= 1'b1;
                    end
                end
                ia_rearm: begin
                    if (!intr_i)
                        state_q <= ia_idle;             // wait for intr to drop
                end
                default: state_q <= ia_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ia_second && rsp_i.done)
            vector_q <= rsp_i.rdata[7:0];
    end

endmodule

// File: source/biu_top.sv
////////////////////////////////////////////////////////////////////////////
// bus interface unit top level
// prefetch queue, exec port and inta sequencer sharing one bus engine
////////////////////////////////////////////////////////////////////////////
module biu_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ready_i,
    input  logic              hold_i,
    input  logic              intr_i,
    output logic              hlda_o,
    output logic [19:0]       a_o,
    inout  wire  [7:0]        ad_io,
    output logic              ale_o,
    output logic              rd_n_o,
    output logic              wr_n_o,
    output logic              inta_n_o,
    output logic              den_n_o,
    output logic              dt_r_o,
    output logic              iom_o,
    input  logic              if_i,
    input  logic              flush_i,
    input  logic [19:0]       flush_addr_i,
    input  logic              pop_i,
    output logic [7:0]        byte_o,
    output logic              valid_o,
    input  logic              exec_req_i,
    input  biu_pkg::bus_req_t exec_req_data_i,
    output biu_pkg::bus_rsp_t exec_rsp_o,
    output logic [7:0]        vector_o,
    output logic              vector_valid_o
);
    import biu_pkg::*;

    logic     pf_req;
    bus_req_t pf_req_data;
    bus_rsp_t pf_rsp;
    logic     ia_req;
    bus_req_t ia_req_data;
    bus_rsp_t ia_rsp;
    logic     cyc_start;
    bus_req_t cyc_req;
    bus_rsp_t cyc_rsp;

    bus_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .pf_req_i    (pf_req),
        .exec_req_i  (exec_req_i),
        .ia_req_i    (ia_req),
        .pf_data_i   (pf_req_data),
        .exec_data_i (exec_req_data_i),
        .ia_data_i   (ia_req_data),
        .pf_rsp_o    (pf_rsp),
        .exec_rsp_o  (exec_rsp_o),
        .ia_rsp_o    (ia_rsp),
        .hold_i      (hold_i),
        .hlda_o      (hlda_o),
        .start_o     (cyc_start),
        .cyc_req_o   (cyc_req),
        .cyc_rsp_i   (cyc_rsp)
    );

    bus_cycle_fsm u_cycle (
        .clk      (clk),
        .rst      (rst),
        .start_i  (cyc_start),
        .req_i    (cyc_req),
        .rsp_o    (cyc_rsp),
        .float_i  (hlda_o),      // bus handed to the external master
        .ready_i  (ready_i),
        .a_o      (a_o),
        .ad_io    (ad_io),
        .ale_o    (ale_o),
        .rd_n_o   (rd_n_o),
        .wr_n_o   (wr_n_o),
        .inta_n_o (inta_n_o),
        .den_n_o  (den_n_o),
        .dt_r_o   (dt_r_o),
        .iom_o    (iom_o)
    );

    prefetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_prefetch (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .flush_addr_i (flush_addr_i),
        .pop_i        (pop_i),
        .byte_o       (byte_o),
        .valid_o      (valid_o),
        .req_o        (pf_req),
        .req_data_o   (pf_req_data),
        .rsp_i        (pf_rsp)
    );

    intr_ack_ctrl u_intr (
        .clk            (clk),
        .rst            (rst),
        .intr_i         (intr_i),
        .if_i           (if_i),
        .req_o          (ia_req),
        .req_data_o     (ia_req_data),
        .rsp_i          (ia_rsp),
        .vector_o       (vector_o),
        .vector_valid_o (vector_valid_o)
    );

endmodule

// File: dv/bus_memory_model.sv
////////////////////////////////////////////////////////////////////////////
// memory and I/O responder for the multiplexed 8-bit bus
// address latch on ale, read and write byte service, inta vector,
// random ready stretches
////////////////////////////////////////////////////////////////////////////
module bus_memory_model #(
    parameter logic [7:0]  INTA_VECTOR = 8'hff,
    parameter logic [31:0] SEED        = 32'h830c_a26f
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [19:0] a_i,
    input  logic        ale_i,
    input  logic        iom_i,
    input  logic        rd_n_i,
    input  logic        wr_n_i,
    input  logic        inta_n_i,
    inout  wire  [7:0]  ad_io,
    output logic        ready_o
);

    logic [7:0]  mem [logic [20:0]];   // written bytes, keyed {io, addr}
    logic [20:0] key_q;
    logic [7:0]  rd_byte_q;
    integer      seed = SEED;

    // power-up contents depend on every address bit
    function automatic logic [7:0] fill_byte(input logic [20:0] key);
        return key[7:0] ^ key[15:8] ^ {3'b000, key[20:16]};
    endfunction

    function automatic logic [7:0] lookup(input logic [20:0] key);
        return mem.exists(key) ? mem[key] : fill_byte(key);
    endfunction

    always @(posedge clk) begin
        if (ale_i) begin
            key_q     <= {iom_i, a_i[19:8], ad_io};          // low byte taken off ad
            rd_byte_q <= lookup({iom_i, a_i[19:8], ad_io});
        end
        if (!wr_n_i)
            mem[key_q] = ad_io;                             // last value in T4 stands
    end

    // ready drops for short random stretches
    always @(posedge clk or negedge rst) begin
        if (!rst)
            ready_o <= 1'b1;
        else if (ready_o)
            ready_o <= ($random(seed) & 3) != 0;
        else
            ready_o <= ($random(seed) & 1) != 0;
    end

    assign ad_io = !rd_n_i   ? rd_byte_q :
                   !inta_n_i ? INTA_VECTOR : 8'hzz;

endmodule

// File: dv/biu_tb.sv
////////////////////////////////////////////////////////////////////////////
// bus interface unit testbench
// random exec traffic, prefetch flush, hold window and one interrupt
// checks are concurrent and immediate assertions, plus a watchdog
////////////////////////////////////////////////////////////////////////////
module biu_tb;
    import biu_pkg::*;

    localparam logic [7:0]  INTA_VECTOR = 8'h4c;
    localparam logic [7:0]  PARK_BYTE   = 8'hc3;       // hold master's bus pattern
    localparam logic [19:0] MEM_BASE    = 20'h5_a300;
    localparam logic [19:0] FLUSH_ADDR  = 20'h4_1e3b;
    localparam int          NUM_OPS     = 120;
    localparam int          HOLD_CYCLES = 10;
    // about 160 cycles per op covers a word write plus its read back
    localparam int          TIMEOUT_CYCLES = NUM_OPS * 160 + 800;

    logic        clk;
    logic        rst;
    logic        ready_i;
    logic        hold_i;
    logic        intr_i;
    logic        hlda_o;
    logic [19:0] a_o;
    wire  [7:0]  ad_io;
    logic        ale_o;
    logic        rd_n_o;
    logic        wr_n_o;
    logic        inta_n_o;
    logic        den_n_o;
    logic        dt_r_o;
    logic        iom_o;
    logic        if_i;
    logic        flush_i;
    logic [19:0] flush_addr_i;
    logic        pop_i;
    logic [7:0]  byte_o;
    logic        valid_o;
    logic        exec_req_i;
    bus_req_t    exec_req_data_i;
    bus_rsp_t    exec_rsp_o;
    logic [7:0]  vector_o;
    logic        vector_valid_o;

    integer      seed = 32'h830c_a26f;
    int          cycle_count = 0;
    int          errors = 0;
    logic        flush_pending = 1'b0;
    logic [7:0]  shadow [logic [20:0]];
    logic [19:0] cur_addr;
    logic [15:0] cur_wdata;
    logic [7:0]  exp_wr_byte;
    logic        cmd_low;
    int          strobe_cycles;
    logic        ready_seen;       // ready already taken in this strobe
    logic        inta_prev;
    int          inta_falls;
    logic [19:0] pf_addr;
    int          pf_pops;

    biu_top #(.QUEUE_DEPTH(4)) dut (.*);

    bus_memory_model #(.INTA_VECTOR(INTA_VECTOR)) u_mem (
        .clk      (clk),
        .rst      (rst),
        .a_i      (a_o),
        .ale_i    (ale_o),
        .iom_i    (iom_o),
        .rd_n_i   (rd_n_o),
        .wr_n_i   (wr_n_o),
        .inta_n_i (inta_n_o),
        .ad_io    (ad_io),
        .ready_o  (ready_i)
    );

    assign ad_io       = hlda_o ? PARK_BYTE : 8'hzz;
    assign cmd_low     = !rd_n_o || !wr_n_o || !inta_n_o;
    assign exp_wr_byte = (a_o == cur_addr) ? cur_wdata[7:0] : cur_wdata[15:8];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [7:0] shadow_byte(input logic io, input logic [19:0] addr);
        logic [20:0] key;
        key = {io, addr};
        return shadow.exists(key) ? shadow[key] : key[7:0] ^ key[15:8] ^ {3'b000, key[20:16]};
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("Error at time %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic exec_access(input cycle_kind_e kind, input logic [19:0] addr,
                               input logic word, input logic [15:0] wdata,
                               output logic [15:0] rdata);
        cur_addr        = addr;
        cur_wdata       = wdata;
        exec_req_i      <= 1'b1;
        exec_req_data_i <= '{addr: addr, wdata: wdata, kind: kind, word: word};
        do
            @(posedge clk);
        while (!exec_rsp_o.done);
        rdata = exec_rsp_o.rdata;
        exec_req_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic random_exec_op();
        logic [31:0] r;
        logic        io;
        logic        word;
        logic [19:0] addr;
        logic [15:0] rdata;
        r    = $random(seed);
        io   = r[0];
        word = r[2];
        addr = io ? {15'h0000, r[8:4]} : MEM_BASE + 20'(r[8:4]);
        if (r[1]) begin
            exec_access(io ? cyc_io_wr : cyc_mem_wr, addr, word, r[31:16], rdata);
            shadow[{io, addr}] = r[23:16];
            if (word)
                shadow[{io, addr + 20'd1}] = r[31:24];
            exec_access(io ? cyc_io_rd : cyc_mem_rd, addr, word, 16'h0000, rdata);
            assert (rdata[7:0] == r[23:16] && (!word || rdata[15:8] == r[31:24]))
                else report_failure($sformatf("read back %h at %h after writing %h",
                                              rdata, addr, r[31:16]));
        end else begin
            exec_access(io ? cyc_io_rd : cyc_mem_rd, addr, word, 16'h0000, rdata);
            assert (rdata[7:0] == shadow_byte(io, addr))
                else report_failure($sformatf("low byte %h read at %h", rdata[7:0], addr));
            if (word)
                assert (rdata[15:8] == shadow_byte(io, addr + 20'd1))
                    else report_failure($sformatf("high byte %h read at %h", rdata[15:8], addr));
        end
    endtask

    task automatic run_hold_window();
        hold_i <= 1'b1;
        do
            @(posedge clk);
        while (!hlda_o);
        repeat (HOLD_CYCLES) @(posedge clk);
        hold_i <= 1'b0;
        do
            @(posedge clk);
        while (hlda_o);
    endtask

    task automatic run_interrupt();
        int falls_before;
        falls_before = inta_falls;
        intr_i <= 1'b1;
        if_i   <= 1'b1;
        do
            @(posedge clk);
        while (!vector_valid_o);
        assert (inta_falls - falls_before == 2 && vector_o == INTA_VECTOR)
            else report_failure($sformatf("%0d inta pulses, vector %h",
                                          inta_falls - falls_before, vector_o));
        intr_i <= 1'b0;
        if_i   <= 1'b0;
        @(posedge clk);
    endtask

    // strobe age, ready taken, inta pulses
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            strobe_cycles <= 0;
            ready_seen    <= 1'b0;
            inta_prev     <= 1'b1;
            inta_falls    <= 0;
        end else begin
            inta_prev <= inta_n_o;
            if (inta_prev && !inta_n_o)
                inta_falls <= inta_falls + 1;
            if (!cmd_low) begin
                strobe_cycles <= 0;
                ready_seen    <= 1'b0;
            end else begin
                strobe_cycles <= strobe_cycles + 1;
                if (strobe_cycles >= 1 && ready_i)
                    ready_seen <= 1'b1;                     // T3 or tw with ready
            end
        end
    end

    // prefetch consumer pops at most every other cycle
    initial begin
        pop_i        <= 1'b0;
        flush_i      <= 1'b0;
        flush_addr_i <= 20'h00000;
        forever begin
            @(posedge clk);
            if (flush_pending) begin
                flush_i       <= 1'b1;
                flush_addr_i  <= FLUSH_ADDR;
                pop_i         <= 1'b0;
                flush_pending <= 1'b0;
            end else begin
                flush_i <= 1'b0;
                pop_i   <= !pop_i && !flush_i && valid_o && (cycle_count % 3 != 0);
            end
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            pf_addr <= 20'h00000;
            pf_pops <= 0;
        end else if (flush_i) begin
            pf_addr <= flush_addr_i;
            pf_pops <= 0;
        end else if (pop_i && valid_o) begin
            assert (byte_o == shadow_byte(1'b0, pf_addr))
                else report_failure($sformatf("prefetch byte %h for %h", byte_o, pf_addr));
            pf_addr <= pf_addr + 20'd1;
            pf_pops <= pf_pops + 1;
        end
    end

    ad_carries_write: assert property (@(posedge clk) disable iff (!rst)
        !wr_n_o |-> ad_io == exp_wr_byte)
        else report_failure("ad does not carry the write byte");

    dir_follows_cmd: assert property (@(posedge clk) disable iff (!rst)
        cmd_low |-> (!den_n_o && dt_r_o == !wr_n_o))
        else report_failure("den or dt/r wrong during a command strobe");

    wait_keeps_strobe: assert property (@(posedge clk) disable iff (!rst)
        (cmd_low && strobe_cycles >= 1 && !ready_seen && !ready_i) |=> cmd_low)
        else report_failure("strobe released while ready was low");

    no_ale_in_cmd: assert property (@(posedge clk) disable iff (!rst)
        cmd_low |-> !ale_o)
        else report_failure("ale high while a command strobe is low");

    hold_bus_quiet: assert property (@(posedge clk) disable iff (!rst)
        hlda_o |-> (!ale_o && rd_n_o && wr_n_o && inta_n_o && den_n_o && ad_io == PARK_BYTE))
        else report_failure("bus not released during hold");

    hlda_after_idle: assert property (@(posedge clk) disable iff (!rst)
        (cmd_low || ale_o || !den_n_o) |=> !hlda_o)
        else report_failure("hlda rose while a bus cycle was active");

    vector_value: assert property (@(posedge clk) disable iff (!rst)
        vector_valid_o |-> vector_o == INTA_VECTOR)
        else report_failure("wrong interrupt vector");

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count <= cycle_count + 1;
        end
        $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst             <= 1'b0;
        hold_i          <= 1'b0;
        intr_i          <= 1'b0;
        if_i            <= 1'b0;
        exec_req_i      <= 1'b0;
        exec_req_data_i <= '0;
        cur_addr        = 20'h00000;
        cur_wdata       = 16'h0000;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_OPS; i++) begin
            if (i == NUM_OPS / 3)
                run_hold_window();
            if (i == NUM_OPS / 2)
                flush_pending <= 1'b1;
            if (i == 2 * NUM_OPS / 3)
                run_interrupt();
            random_exec_op();
        end
        while (pf_pops < 8)
            @(posedge clk);                                 // pops since the flush
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/biu_pkg.sv
source/bus_arbiter.sv
source/bus_cycle_fsm.sv
source/prefetch_queue.sv
source/intr_ack_ctrl.sv
source/biu_top.sv
dv/bus_memory_model.sv
dv/biu_tb.sv

// File: Makefile
TOP := biu_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) \
		-Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
